// ==== logic/tiny900_pkg.sv ====
// ISA definitions; opcodes 13 to 15 are undefined and execute as NOP, flags sit as {S,Z,V,C}
package tiny900_pkg;

    localparam int DATA_W = 16;
    localparam int ADDR_W = 24;
    // high byte of every LD/ST data address
    localparam logic [7:0] DATA_SEG = 8'h01;

    // bit positions inside the flag register
    localparam int FLAG_S = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_C = 0;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_LDH  = 4'd2,
        OP_ADD  = 4'd3,
        OP_SUB  = 4'd4,
        OP_AND  = 4'd5,
        OP_OR   = 4'd6,
        OP_XOR  = 4'd7,
        OP_CP   = 4'd8,
        OP_LD   = 4'd9,
        OP_ST   = 4'd10,
        OP_JR   = 4'd11,
        OP_ADDI = 4'd12
    } opcode_t;

    typedef enum logic [2:0] {
        CC_T, CC_Z, CC_NZ, CC_C, CC_NC, CC_MI, CC_PL, CC_F
    } cond_t;

    typedef enum logic [2:0] {
        ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_HIGH_B
    } alu_op_t;

    typedef enum logic [1:0] {
        S_FETCH, S_DECODE, S_EXEC, S_MEM
    } state_t;

endpackage

// ==== logic/tiny900_alu.sv ====
// combinational execute stage; flags come out for every op but only arithmetic and logic store them
module tiny900_alu (
    input  logic [tiny900_pkg::DATA_W-1:0] a,
    input  logic [tiny900_pkg::DATA_W-1:0] b,
    input  logic [tiny900_pkg::DATA_W-1:0] imm,
    input  logic                           sel_imm,
    input  tiny900_pkg::alu_op_t           alu_op,
    input  logic [3:0]                     flags,
    input  tiny900_pkg::cond_t             branch_cond,
    output logic [tiny900_pkg::DATA_W-1:0] result,
    output logic [3:0]                     nx_flags,
    output logic                           take_branch
);

    logic [tiny900_pkg::DATA_W-1:0] opb;
    // one extra bit holds carry or borrow
    logic [tiny900_pkg::DATA_W:0]   add_r;
    logic [tiny900_pkg::DATA_W:0]   sub_r;

    assign opb   = sel_imm ? imm : b;
    assign add_r = {1'b0, a} + {1'b0, opb};
    assign sub_r = {1'b0, a} - {1'b0, opb};

    always_comb begin
        case (alu_op)
            tiny900_pkg::ALU_ADD:    result = add_r[15:0];
            tiny900_pkg::ALU_SUB:    result = sub_r[15:0];
            tiny900_pkg::ALU_AND:    result = a & opb;
            tiny900_pkg::ALU_OR:     result = a | opb;
            tiny900_pkg::ALU_XOR:    result = a ^ opb;
            // LDH keeps the low byte of rd
            tiny900_pkg::ALU_HIGH_B: result = {opb[7:0], a[7:0]};
            default:                 result = opb;
        endcase
    end

    always_comb begin
        nx_flags = flags;
        nx_flags[tiny900_pkg::FLAG_S] = result[15];
        nx_flags[tiny900_pkg::FLAG_Z] = (result == '0);
        case (alu_op)
            tiny900_pkg::ALU_ADD: begin
                nx_flags[tiny900_pkg::FLAG_C] = add_r[16];
                nx_flags[tiny900_pkg::FLAG_V] = (a[15] == opb[15]) && (add_r[15] != a[15]);
            end
            tiny900_pkg::ALU_SUB: begin
                // borrow out of bit 15
                nx_flags[tiny900_pkg::FLAG_C] = sub_r[16];
                nx_flags[tiny900_pkg::FLAG_V] = (a[15] != opb[15]) && (sub_r[15] != a[15]);
            end
            default: begin
                nx_flags[tiny900_pkg::FLAG_C] = 1'b0;
                nx_flags[tiny900_pkg::FLAG_V] = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (branch_cond)
            tiny900_pkg::CC_T:  take_branch = 1'b1;
            tiny900_pkg::CC_Z:  take_branch = flags[tiny900_pkg::FLAG_Z];
            tiny900_pkg::CC_NZ: take_branch = !flags[tiny900_pkg::FLAG_Z];
            tiny900_pkg::CC_C:  take_branch = flags[tiny900_pkg::FLAG_C];
            tiny900_pkg::CC_NC: take_branch = !flags[tiny900_pkg::FLAG_C];
            tiny900_pkg::CC_MI: take_branch = flags[tiny900_pkg::FLAG_S];
            tiny900_pkg::CC_PL: take_branch = !flags[tiny900_pkg::FLAG_S];
            default:            take_branch = 1'b0;
        endcase
    end

endmodule

// ==== logic/tiny900_regs.sv ====
// eight-word register bank and flags; dump reads are combinational and ignore cen
module tiny900_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cen,
    input  logic [2:0]                     rd,
    input  logic [2:0]                     rs,
    input  logic                           reg_we,
    input  logic                           flag_we,
    input  logic                           ld_sel,
    input  logic [tiny900_pkg::DATA_W-1:0] result,
    input  logic [tiny900_pkg::DATA_W-1:0] load_data,
    input  logic [3:0]                     nx_flags,
    output logic [tiny900_pkg::DATA_W-1:0] rd_val,
    output logic [tiny900_pkg::DATA_W-1:0] rs_val,
    output logic [3:0]                     flags,
    input  logic [7:0]                     dmp_addr,
    output logic [7:0]                     dmp_din
);

    logic [tiny900_pkg::DATA_W-1:0] bank [8];
    logic [tiny900_pkg::DATA_W-1:0] wr_data;
    logic [tiny900_pkg::DATA_W-1:0] dmp_word;

    // LD takes the bus word, everything else the ALU
    assign wr_data = ld_sel ? load_data : result;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                bank[i] <= '0;
            end
            flags <= 4'd0;
        end else if (cen) begin
            if (reg_we) begin
                bank[rd] <= wr_data;
            end
            if (flag_we) begin
                flags <= nx_flags;
            end
        end
    end

    assign rd_val = bank[rd];
    assign rs_val = bank[rs];

    // two dump bytes per register, low byte first
    assign dmp_word = bank[dmp_addr[3:1]];

    always_comb begin
        if (dmp_addr < 8'd16) begin
            dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
        end else if (dmp_addr == 8'd16) begin
            dmp_din = {4'b0000, flags};
        end else begin
            dmp_din = 8'h00;
        end
    end

endmodule

// ==== logic/tiny900_ramctl.sv ====
// bus side; one word per access, reads answer on the next cen edge and writes need no ack
module tiny900_ramctl #(
    parameter logic [tiny900_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cen,
    input  tiny900_pkg::state_t            state,
    input  logic                           mem_rd,
    input  logic                           mem_wr,
    input  logic                           pc_load,
    input  logic                           take_branch,
    input  logic [tiny900_pkg::DATA_W-1:0] imm,
    input  logic [tiny900_pkg::DATA_W-1:0] rs_val,
    input  logic [tiny900_pkg::DATA_W-1:0] rd_val,
    input  logic [tiny900_pkg::DATA_W-1:0] din,
    output logic [tiny900_pkg::ADDR_W-1:0] addr,
    output logic [tiny900_pkg::DATA_W-1:0] dout,
    output logic [1:0]                     we,
    output logic [tiny900_pkg::ADDR_W-1:0] pc,
    output logic [tiny900_pkg::DATA_W-1:0] load_data
);

    localparam int EXT_W = tiny900_pkg::ADDR_W - tiny900_pkg::DATA_W - 1;

    logic [tiny900_pkg::ADDR_W-1:0] br_off;
    logic [tiny900_pkg::ADDR_W-1:0] pc_next;
    logic [tiny900_pkg::ADDR_W-1:0] data_addr;

    // word offset, so shifted left once
    assign br_off  = {{EXT_W{imm[15]}}, imm, 1'b0};
    assign pc_next = pc + 24'd2 + (take_branch ? br_off : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (cen && pc_load) begin
            pc <= pc_next;
        end
    end

    // LD/ST always hit the data segment, word aligned
    assign data_addr = {tiny900_pkg::DATA_SEG, rs_val[15:1], 1'b0};
    assign addr      = (mem_rd || mem_wr) ? data_addr : pc;

    assign dout = rd_val;
    assign we   = {2{cen && mem_wr}};

    // bus word is load data only during MEM
    assign load_data = (state == tiny900_pkg::S_MEM) ? din : '0;

    a_addr_aligned: assert property (@(posedge clk) disable iff (reset) !addr[0]);

endmodule

// ==== logic/tiny900_ctrl.sv ====
// decode FSM; the instruction word is taken from din in DECODE, one read cycle after FETCH
module tiny900_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cen,
    input  logic [tiny900_pkg::DATA_W-1:0] din,
    output tiny900_pkg::state_t            state,
    output tiny900_pkg::alu_op_t           alu_op,
    output logic                           sel_imm,
    output logic [tiny900_pkg::DATA_W-1:0] imm,
    output logic [2:0]                     rd,
    output logic [2:0]                     rs,
    output logic                           reg_we,
    output logic                           flag_we,
    output logic                           mem_rd,
    output logic                           mem_wr,
    output logic                           pc_load,
    output tiny900_pkg::cond_t             branch_cond,
    output logic                           ld_sel
);

    logic [tiny900_pkg::DATA_W-1:0] ir;
    tiny900_pkg::opcode_t           op;
    logic                           in_exec;
    logic                           in_mem;
    logic                           writes_rd;
    logic                           sets_flags;
    logic                           is_mem_op;

    assign op      = tiny900_pkg::opcode_t'(ir[15:12]);
    assign rd      = ir[11:9];
    assign rs      = ir[8:6];
    assign in_exec = (state == tiny900_pkg::S_EXEC);
    assign in_mem  = (state == tiny900_pkg::S_MEM);

    assign is_mem_op = (op == tiny900_pkg::OP_LD) || (op == tiny900_pkg::OP_ST);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= tiny900_pkg::S_FETCH;
        end else if (cen) begin
            case (state)
                tiny900_pkg::S_FETCH:  state <= tiny900_pkg::S_DECODE;
                tiny900_pkg::S_DECODE: state <= tiny900_pkg::S_EXEC;
                tiny900_pkg::S_EXEC:   state <= is_mem_op ? tiny900_pkg::S_MEM
                                                          : tiny900_pkg::S_FETCH;
                default:               state <= tiny900_pkg::S_FETCH;
            endcase
        end
    end

    // word requested in FETCH is on din now
    always_ff @(posedge clk) begin
        if (cen && state == tiny900_pkg::S_DECODE) begin
            ir <= din;
        end
    end

    always_comb begin
        case (op)
            tiny900_pkg::OP_LDH:  alu_op = tiny900_pkg::ALU_HIGH_B;
            tiny900_pkg::OP_ADD,
            tiny900_pkg::OP_ADDI: alu_op = tiny900_pkg::ALU_ADD;
            tiny900_pkg::OP_SUB,
            tiny900_pkg::OP_CP:   alu_op = tiny900_pkg::ALU_SUB;
            tiny900_pkg::OP_AND:  alu_op = tiny900_pkg::ALU_AND;
            tiny900_pkg::OP_OR:   alu_op = tiny900_pkg::ALU_OR;
            tiny900_pkg::OP_XOR:  alu_op = tiny900_pkg::ALU_XOR;
            default:              alu_op = tiny900_pkg::ALU_PASS_B;
        endcase
    end

    assign sel_imm = (op == tiny900_pkg::OP_LDI) || (op == tiny900_pkg::OP_LDH)
                  || (op == tiny900_pkg::OP_ADDI);

    // ADDI and JR offsets are signed, loads of a byte are not
    assign imm = (op == tiny900_pkg::OP_ADDI || op == tiny900_pkg::OP_JR)
               ? {{8{ir[7]}}, ir[7:0]}
               : {8'h00, ir[7:0]};

    assign writes_rd = op inside {tiny900_pkg::OP_LDI, tiny900_pkg::OP_LDH,
                                  tiny900_pkg::OP_ADD, tiny900_pkg::OP_SUB,
                                  tiny900_pkg::OP_AND, tiny900_pkg::OP_OR,
                                  tiny900_pkg::OP_XOR, tiny900_pkg::OP_ADDI};

    assign sets_flags = op inside {tiny900_pkg::OP_ADD, tiny900_pkg::OP_SUB,
                                   tiny900_pkg::OP_AND, tiny900_pkg::OP_OR,
                                   tiny900_pkg::OP_XOR, tiny900_pkg::OP_CP,
                                   tiny900_pkg::OP_ADDI};

    // LD writes back one cycle later, in MEM
    assign reg_we  = (in_exec && writes_rd) || (in_mem && op == tiny900_pkg::OP_LD);
    assign flag_we = in_exec && sets_flags;
    assign mem_rd  = in_exec && (op == tiny900_pkg::OP_LD);
    assign mem_wr  = in_exec && (op == tiny900_pkg::OP_ST);
    assign pc_load = in_exec;
    assign ld_sel  = (op == tiny900_pkg::OP_LD);

    // never jump unless the word is a JR
    assign branch_cond = (op == tiny900_pkg::OP_JR) ? tiny900_pkg::cond_t'(ir[11:9])
                                                    : tiny900_pkg::CC_F;

    // a store writes once, then moves on to its MEM slot
    a_wr_once: assert property (@(posedge clk) disable iff (reset)
        cen && mem_wr |=> state == tiny900_pkg::S_MEM);

    // a register write is the last step of its instruction
    a_reg_we_last: assert property (@(posedge clk) disable iff (reset)
        cen && reg_we |=> state == tiny900_pkg::S_FETCH);

endmodule

// ==== logic/tiny900.sv ====
// 16-bit core top; no interrupts and no bus wait, every access is one aligned word
module tiny900 #(
    parameter logic [tiny900_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cen,

    output logic [tiny900_pkg::ADDR_W-1:0] addr,
    input  logic [tiny900_pkg::DATA_W-1:0] din,
    output logic [tiny900_pkg::DATA_W-1:0] dout,
    output logic [1:0]                     we,

    // register dump
    input  logic [7:0]                     dmp_addr,
    output logic [7:0]                     dmp_din
);

    // decode strobes
    tiny900_pkg::state_t            state;
    tiny900_pkg::alu_op_t           alu_op;
    tiny900_pkg::cond_t             branch_cond;
    logic                           sel_imm;
    logic [tiny900_pkg::DATA_W-1:0] imm;
    logic [2:0]                     rd;
    logic [2:0]                     rs;
    logic                           reg_we;
    logic                           flag_we;
    logic                           mem_rd;
    logic                           mem_wr;
    logic                           pc_load;
    logic                           ld_sel;

    // register bank outputs
    logic [tiny900_pkg::DATA_W-1:0] rd_val;
    logic [tiny900_pkg::DATA_W-1:0] rs_val;
    logic [3:0]                     flags;

    // execute results
    logic [tiny900_pkg::DATA_W-1:0] result;
    logic [3:0]                     nx_flags;
    logic                           take_branch;

    logic [tiny900_pkg::DATA_W-1:0] load_data;

    tiny900_ctrl u_ctrl (
        .clk            ( clk           ),
        .reset          ( reset         ),
        .cen            ( cen           ),
        .din            ( din           ),
        .state          ( state         ),
        .alu_op         ( alu_op        ),
        .sel_imm        ( sel_imm       ),
        .imm            ( imm           ),
        .rd             ( rd            ),
        .rs             ( rs            ),
        .reg_we         ( reg_we        ),
        .flag_we        ( flag_we       ),
        .mem_rd         ( mem_rd        ),
        .mem_wr         ( mem_wr        ),
        .pc_load        ( pc_load       ),
        .branch_cond    ( branch_cond   ),
        .ld_sel         ( ld_sel        )
    );

    tiny900_alu u_alu (
        .a              ( rd_val        ),
        .b              ( rs_val        ),
        .imm            ( imm           ),
        .sel_imm        ( sel_imm       ),
        .alu_op         ( alu_op        ),
        .flags          ( flags         ),
        .branch_cond    ( branch_cond   ),
        .result         ( result        ),
        .nx_flags       ( nx_flags      ),
        .take_branch    ( take_branch   )
    );

    tiny900_regs u_regs (
        .clk            ( clk           ),
        .reset          ( reset         ),
        .cen            ( cen           ),
        .rd             ( rd            ),
        .rs             ( rs            ),
        .reg_we         ( reg_we        ),
        .flag_we        ( flag_we       ),
        .ld_sel         ( ld_sel        ),
        .result         ( result        ),
        .load_data      ( load_data     ),
        .nx_flags       ( nx_flags      ),
        .rd_val         ( rd_val        ),
        .rs_val         ( rs_val        ),
        .flags          ( flags         ),
        .dmp_addr       ( dmp_addr      ),
        .dmp_din        ( dmp_din       )
    );

    tiny900_ramctl #(
        .RESET_PC       ( RESET_PC      )
    ) u_ramctl (
        .clk            ( clk           ),
        .reset          ( reset         ),
        .cen            ( cen           ),
        .state          ( state         ),
        .mem_rd         ( mem_rd        ),
        .mem_wr         ( mem_wr        ),
        .pc_load        ( pc_load       ),
        .take_branch    ( take_branch   ),
        .imm            ( imm           ),
        .rs_val         ( rs_val        ),
        .rd_val         ( rd_val        ),
        .din            ( din           ),
        .addr           ( addr          ),
        .dout           ( dout          ),
        .we             ( we            ),
        // pc is kept internal to the bus block
        .pc             (               ),
        .load_data      ( load_data     )
    );

endmodule

// ==== test/tiny900_model.sv ====
// ISA reference model stepped once per cen cycle; data fill pattern must match the bus memory
module tiny900_model #(
    parameter logic [23:0] RESET_PC = '0
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] regs [8];
    logic        s_f, z_f, v_f, c_f;
    logic [23:0] pc;
    logic [23:0] last_fetch;
    logic        have_fetch;
    logic        halted;
    logic [15:0] ir;
    int          phase;
    int          errors = 0;
    int          checks = 0;
    int          retired;
    logic [15:0] pmem [logic [23:0]];
    logic [15:0] dmem [logic [23:0]];

    // untouched data words, a function of every address bit
    function automatic logic [15:0] fill_word(input logic [23:0] a);
        return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] read_data(input logic [23:0] a);
        return dmem.exists(a) ? dmem[a] : fill_word(a);
    endfunction

    task automatic load_word(input logic [23:0] a, input logic [15:0] w);
        pmem[a] = w;
    endtask

    task automatic reset_state();
        for (int i = 0; i < 8; i++) begin
            regs[i] = 16'h0000;
        end
        {s_f, z_f, v_f, c_f} = 4'b0000;
        pc = RESET_PC;
        have_fetch = 1'b0;
        halted = 1'b0;
        phase = 0;
        retired = 0;
    endtask

    task automatic check_addr(input string what, input logic [23:0] got, input logic [23:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: %s is %06h, expected %06h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: %s is %04h, expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    // add or subtract with S Z V C, C is the borrow on subtract
    task automatic arith(input logic [15:0] a, input logic [15:0] b, input logic sub,
                         output logic [15:0] r);
        logic [16:0] wide;
        wide = sub ? {1'b0, a} - {1'b0, b} : {1'b0, a} + {1'b0, b};
        r = wide[15:0];
        c_f = wide[16];
        v_f = sub ? (a[15] != b[15]) && (r[15] != a[15]) : (a[15] == b[15]) && (r[15] != a[15]);
        s_f = r[15];
        z_f = (r == 16'h0000);
    endtask

    task automatic logic_flags(input logic [15:0] r);
        s_f = r[15];
        z_f = (r == 16'h0000);
        v_f = 1'b0;
        c_f = 1'b0;
    endtask

    function automatic logic cond_met(input logic [2:0] cc);
        case (tiny900_pkg::cond_t'(cc))
            tiny900_pkg::CC_T:  return 1'b1;
            tiny900_pkg::CC_Z:  return z_f;
            tiny900_pkg::CC_NZ: return !z_f;
            tiny900_pkg::CC_C:  return c_f;
            tiny900_pkg::CC_NC: return !c_f;
            tiny900_pkg::CC_MI: return s_f;
            tiny900_pkg::CC_PL: return !s_f;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic logic [7:0] dump_byte(input logic [7:0] a);
        if (a < 8'd16) begin
            return a[0] ? regs[a[3:1]][15:8] : regs[a[3:1]][7:0];
        end else if (a == 8'd16) begin
            return {4'b0000, s_f, z_f, v_f, c_f};
        end
        return 8'h00;
    endfunction

    task automatic execute(input tiny900_pkg::opcode_t op, input logic [2:0] rd,
                           input logic [2:0] rs);
        logic [15:0] sx;
        logic [15:0] r;
        logic [23:0] next_pc;
        sx = {{8{ir[7]}}, ir[7:0]};
        next_pc = pc + 24'd2;
        case (op)
            tiny900_pkg::OP_LDI:  regs[rd] = {8'h00, ir[7:0]};
            tiny900_pkg::OP_LDH:  regs[rd] = {ir[7:0], regs[rd][7:0]};
            tiny900_pkg::OP_ADD:  arith(regs[rd], regs[rs], 1'b0, regs[rd]);
            tiny900_pkg::OP_SUB:  arith(regs[rd], regs[rs], 1'b1, regs[rd]);
            tiny900_pkg::OP_CP:   arith(regs[rd], regs[rs], 1'b1, r);
            tiny900_pkg::OP_ADDI: arith(regs[rd], sx, 1'b0, regs[rd]);
            tiny900_pkg::OP_AND: begin
                regs[rd] = regs[rd] & regs[rs];
                logic_flags(regs[rd]);
            end
            tiny900_pkg::OP_OR: begin
                regs[rd] = regs[rd] | regs[rs];
                logic_flags(regs[rd]);
            end
            tiny900_pkg::OP_XOR: begin
                regs[rd] = regs[rd] ^ regs[rs];
                logic_flags(regs[rd]);
            end
            tiny900_pkg::OP_JR: begin
                if (cond_met(ir[11:9])) begin
                    next_pc = pc + 24'd2 + {{7{sx[15]}}, sx, 1'b0};
                end
            end
            default: ;
        endcase
        pc = next_pc;
    endtask

    // one cen cycle of bus activity: fetch, decode, execute, memory
    task automatic cycle(input logic [23:0] a, input logic [1:0] w, input logic [15:0] d);
        tiny900_pkg::opcode_t op;
        logic [2:0]           rd;
        logic [2:0]           rs;
        logic [23:0]          daddr;
        logic                 is_mem;
        op = tiny900_pkg::opcode_t'(ir[15:12]);
        rd = ir[11:9];
        rs = ir[8:6];
        daddr = {tiny900_pkg::DATA_SEG, regs[rs][15:1], 1'b0};
        is_mem = (op == tiny900_pkg::OP_LD) || (op == tiny900_pkg::OP_ST);
        if (phase == 2 && op == tiny900_pkg::OP_ST) begin
            check_word("write enable of ST", {14'd0, w}, 16'h0003);
            check_word("store data", d, regs[rd]);
            dmem[daddr] = regs[rd];
        end else begin
            check_word("write enable", {14'd0, w}, 16'h0000);
        end
        case (phase)
            0: begin
                check_addr("fetch address", a, pc);
                halted = have_fetch && (pc == last_fetch);
                last_fetch = pc;
                have_fetch = 1'b1;
                phase = 1;
            end
            1: begin
                ir = pmem.exists(pc) ? pmem[pc] : 16'h0000;
                phase = 2;
            end
            2: begin
                check_addr(is_mem ? "data address" : "execute address", a, is_mem ? daddr : pc);
                execute(op, rd, rs);
                retired++;
                phase = is_mem ? 3 : 0;
            end
            default: begin
                if (op == tiny900_pkg::OP_LD) begin
                    regs[rd] = read_data(daddr);
                end
                phase = 0;
            end
        endcase
    endtask

endmodule

// ==== test/tiny900_tb.sv ====
// random programs at RESET_PC with random cen; data words below 0x010000 are never touched
module tiny900_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [23:0] RESET_PC    = 24'h000200;
    localparam logic [31:0] SEED        = 32'h301c_e4a2;
    localparam int          NUM_PROGS   = 6;
    localparam int          PROG_LEN    = 40;
    localparam int          WATCHDOG_NS = NUM_PROGS * 45 * 4 * 4 * 100;

    logic        clk;
    logic        reset;
    logic        cen;
    logic [23:0] addr;
    logic [15:0] din;
    logic [15:0] dout;
    logic [1:0]  we;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_din;
    logic [31:0] cen_rng;
    logic [31:0] gen_rng;
    logic [15:0] mem [logic [23:0]];
    logic [23:0] prev_addr;
    logic        prev_cen;
    logic        prev_valid;

    tiny900 #(.RESET_PC(RESET_PC)) dut0 (
        .clk(clk), .reset(reset), .cen(cen), .addr(addr), .din(din), .dout(dout),
        .we(we), .dmp_addr(dmp_addr), .dmp_din(dmp_din)
    );

    tiny900_model #(.RESET_PC(RESET_PC)) model0 ();

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cen high about three cycles in four
    always @(posedge clk) begin
        cen_rng <= lcg_next(cen_rng);
        cen <= (cen_rng[31:30] != 2'b00);
    end

    // bus memory, read data shows up one cen edge later
    always @(posedge clk) begin
        if (cen) begin
            din <= mem.exists(addr) ? mem[addr] : model0.fill_word(addr);
            if (we == 2'b11) begin
                mem[addr] = dout;
            end
        end
    end

    // outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        if (reset) begin
            prev_valid = 1'b0;
        end else begin
            if (prev_valid && !prev_cen) begin
                model0.check_addr("address across a cen low clock", addr, prev_addr);
            end
            if (cen) begin
                model0.cycle(addr, we, dout);
            end else begin
                model0.check_word("write enable with cen low", {14'd0, we}, 16'h0000);
            end
            prev_addr = addr;
            prev_cen = cen;
            prev_valid = 1'b1;
        end
    end

    task automatic load_program();
        logic [15:0] w;
        logic [1:0]  off;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            gen_rng = lcg_next(gen_rng);
            w = gen_rng[31:16];
            // forward jumps only, never beyond the halt word
            if (w[15:12] == 4'd11) begin
                off = gen_rng[9:8];
                if (int'(off) > PROG_LEN - 2 - i) begin
                    off = 2'(PROG_LEN - 2 - i);
                end
                w[7:0] = {6'd0, off};
            end
            mem[RESET_PC + 24'(2 * i)] = w;
            model0.load_word(RESET_PC + 24'(2 * i), w);
        end
        // JR T,-1 spins on itself
        mem[RESET_PC + 24'(2 * (PROG_LEN - 1))] = 16'hb0ff;
        model0.load_word(RESET_PC + 24'(2 * (PROG_LEN - 1)), 16'hb0ff);
    endtask

    task automatic run_program(input int p);
        int start_errors;
        start_errors = model0.errors;
        @(posedge clk);
        reset <= 1'b1;
        load_program();
        model0.reset_state();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (!model0.halted) begin
            @(negedge clk);
        end
        for (int i = 0; i <= 16; i++) begin
            @(posedge clk);
            dmp_addr <= i[7:0];
            @(negedge clk);
            model0.check_byte($sformatf("dump byte %0d", i), dmp_din, model0.dump_byte(i[7:0]));
        end
        $display("program %0d: %0d instructions, %0d errors", p, model0.retired,
                 model0.errors - start_errors);
    endtask

    initial begin
        reset = 1'b1;
        cen = 1'b0;
        din = 16'h0000;
        dmp_addr = 8'h00;
        cen_rng = SEED;
        gen_rng = lcg_next(SEED ^ 32'h0000_ffff);
        prev_valid = 1'b0;
        prev_cen = 1'b0;
        prev_addr = '0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("programs %0d, checks %0d, errors %0d", NUM_PROGS, model0.checks, model0.errors);
        if (model0.errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: a program never reached its halt loop");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tiny900.f ====
logic/tiny900_pkg.sv
logic/tiny900_alu.sv
logic/tiny900_regs.sv
logic/tiny900_ramctl.sv
logic/tiny900_ctrl.sv
logic/tiny900.sv
test/tiny900_model.sv
test/tiny900_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tiny900_tb \
    -f tiny900.f -o tiny900_sim > build.log 2>&1 &&
./obj_dir/tiny900_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation gave no result"; exit 1; }
exit 0
